// ==== rtl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  localparam int PC_SIZE = 32;
  localparam int LINE_SIZE_BYTES = 16;
  localparam int LINE_BITS = LINE_SIZE_BYTES * 8;
  localparam int INSTR_BITS = 32;
  localparam int L0_SETS = 8;
  localparam int L1_SETS = 64;
  localparam int BTB_ENTRIES = 16;

  localparam int OFFSET_BITS = $clog2(LINE_SIZE_BYTES);
  localparam int WORD_SEL_BITS = $clog2(LINE_BITS / INSTR_BITS);  // instruction within a line
  localparam int ALIGN_BITS = $clog2(INSTR_BITS / 8);
  localparam int L0_INDEX_BITS = $clog2(L0_SETS);
  localparam int L0_TAG_BITS = PC_SIZE - L0_INDEX_BITS - OFFSET_BITS;
  localparam int L1_INDEX_BITS = $clog2(L1_SETS);
  localparam int L1_TAG_BITS = PC_SIZE - L1_INDEX_BITS - OFFSET_BITS;
  localparam int BTB_INDEX_BITS = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_BITS = PC_SIZE - BTB_INDEX_BITS - ALIGN_BITS;

  localparam logic [PC_SIZE-1:0] RESET_PC = 32'h0000_1000;

  typedef logic [LINE_BITS-1:0] cache_line_t;

  typedef struct packed {
    logic [L0_TAG_BITS-1:0]   tag;
    logic [L0_INDEX_BITS-1:0] index;
    logic [OFFSET_BITS-1:0]   offset;
  } l0_addr_t;

  typedef struct packed {
    logic [L1_TAG_BITS-1:0]   tag;
    logic [L1_INDEX_BITS-1:0] index;
    logic [OFFSET_BITS-1:0]   offset;
  } l1_addr_t;

  // same pc word, split differently by each cache level
  typedef union packed {
    logic [PC_SIZE-1:0] word;
    l0_addr_t           l0;
    l1_addr_t           l1;
  } pc_u;

  typedef struct packed {
    logic valid;
    pc_u  pc;
  } l1_req_t;

  typedef struct packed {
    logic        valid;
    pc_u         pc;
    cache_line_t data;
  } l1_fill_t;

  typedef struct packed {
    logic               valid;
    logic [PC_SIZE-1:0] addr;  // line aligned
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    cache_line_t data;
  } mem_rsp_t;

  typedef struct packed {
    logic                  valid;
    logic [PC_SIZE-1:0]    pc;
    logic [INSTR_BITS-1:0] instr;
  } fetch_out_t;

  typedef struct packed {
    logic               valid;
    logic [PC_SIZE-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic               valid;
    logic               taken;
    logic [PC_SIZE-1:0] pc;
    logic [PC_SIZE-1:0] target;
  } bp_update_t;

endpackage

`default_nettype wire

// ==== rtl/l0_instruction_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

// zero-latency lookup that only L1 fills write
module l0_instruction_cache (
  input  logic                   clk,
  input  logic                   reset,
  input  fetch_pkg::pc_u         bp_pred_pc,  // pc being fetched this cycle
  input  fetch_pkg::l1_fill_t    l1_fill,
  output fetch_pkg::cache_line_t cache_line,
  output logic                   cache_hit
);

  import fetch_pkg::*;

  cache_line_t            data_array [L0_SETS];
  logic [L0_TAG_BITS-1:0] tag_array  [L0_SETS];
  logic [L0_SETS-1:0]     valid_bits;

  logic [L0_INDEX_BITS-1:0] pred_index;
  logic [L0_TAG_BITS-1:0]   pred_tag;
  logic [L0_INDEX_BITS-1:0] fill_index;

  assign pred_index = bp_pred_pc.l0.index;
  assign pred_tag   = bp_pred_pc.l0.tag;
  assign fill_index = l1_fill.pc.l0.index;

  // combinational read in the same cycle as the pc
  assign cache_hit  = valid_bits[pred_index] && (tag_array[pred_index] == pred_tag);
  assign cache_line = data_array[pred_index];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
    end else if (l1_fill.valid) begin
      valid_bits[fill_index] <= 1'b1;
    end
  end

  // payload arrays
  always_ff @(posedge clk) begin
    if (l1_fill.valid) begin
      data_array[fill_index] <= l1_fill.data;
      tag_array[fill_index]  <= l1_fill.pc.l0.tag;  // replaces whatever line sat here
    end
  end

  // a fill from the L1 must carry a fully known line
  a_fill_data_known : assert property (
    @(posedge clk) disable iff (reset)
    l1_fill.valid |-> !$isunknown(l1_fill.data)
  ) else $error("l0: fill with unknown data at pc %h", l1_fill.pc.word);

endmodule

`default_nettype wire

// ==== rtl/l1_instruction_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module l1_instruction_cache (
  input  logic                clk,
  input  logic                reset,
  input  fetch_pkg::l1_req_t  l1_req,
  input  fetch_pkg::mem_rsp_t mem_rsp,
  output fetch_pkg::mem_req_t mem_req,
  output fetch_pkg::l1_fill_t l1_fill
);

  import fetch_pkg::*;

  cache_line_t            data_array [L1_SETS];
  logic [L1_TAG_BITS-1:0] tag_array  [L1_SETS];
  logic [L1_SETS-1:0]     valid_bits;

  l1_req_t req_q;         // request being looked up this cycle
  logic    miss_pending;  // waiting on the line memory
  pc_u     miss_pc;
  logic    refill_valid;  // line installed last edge, send it on now
  logic    lookup_hit;
  logic    lookup_miss;
  logic    rsp_accept;
  logic    busy;
  pc_u     fill_pc;

  assign lookup_hit = req_q.valid && valid_bits[req_q.pc.l1.index]
                      && (tag_array[req_q.pc.l1.index] == req_q.pc.l1.tag);
  assign lookup_miss = req_q.valid && !lookup_hit;
  assign rsp_accept  = miss_pending && mem_rsp.valid;
  assign busy        = req_q.valid || miss_pending || refill_valid;

  // one request per miss, line aligned
  assign mem_req.valid = lookup_miss;
  assign mem_req.addr  = {req_q.pc.l1.tag, req_q.pc.l1.index, {OFFSET_BITS{1'b0}}};

  // a refill reads back the line it just installed
  assign fill_pc       = refill_valid ? miss_pc : req_q.pc;
  assign l1_fill.valid = lookup_hit || refill_valid;
  assign l1_fill.pc    = fill_pc;
  assign l1_fill.data  = data_array[fill_pc.l1.index];

  always_ff @(posedge clk) begin
    if (reset) begin
      req_q.valid <= 1'b0;
    end else begin
      req_q.valid <= l1_req.valid;
      if (l1_req.valid) begin
        req_q.pc <= l1_req.pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      miss_pending <= 1'b0;
      refill_valid <= 1'b0;
      valid_bits   <= '0;
    end else begin
      refill_valid <= rsp_accept;
      if (lookup_miss) begin
        miss_pending <= 1'b1;
      end else if (rsp_accept) begin
        miss_pending <= 1'b0;
        valid_bits[miss_pc.l1.index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_miss) begin
      miss_pc <= req_q.pc;
    end
    if (rsp_accept) begin
      data_array[miss_pc.l1.index] <= mem_rsp.data;
      tag_array[miss_pc.l1.index]  <= miss_pc.l1.tag;
    end
  end

  // only one memory miss may be in flight
  a_single_miss : assert property (
    @(posedge clk) disable iff (reset)
    mem_req.valid |-> !miss_pending
  ) else $error("l1: second memory request while a miss is outstanding");

  // the fetch unit has to wait for the fill before asking again
  a_no_req_when_busy : assert property (
    @(posedge clk) disable iff (reset)
    l1_req.valid |-> !busy
  ) else $error("l1: request at pc %h while busy", l1_req.pc.word);

endmodule

`default_nettype wire

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none

// direct-mapped BTB with one two-bit counter per entry
module branch_predictor (
  input  logic                  clk,
  input  logic                  reset,
  input  fetch_pkg::pc_u        fetch_pc,
  input  fetch_pkg::bp_update_t bp_update,
  output fetch_pkg::pc_u        pred_pc
);

  import fetch_pkg::*;

  typedef struct packed {
    logic [BTB_TAG_BITS-1:0] tag;
    logic [PC_SIZE-1:0]      target;
    logic [1:0]              ctr;  // 0 and 1 not taken, 2 and 3 taken
  } btb_entry_t;

  btb_entry_t             btb      [BTB_ENTRIES];
  logic [BTB_ENTRIES-1:0] btb_valid;

  logic [BTB_INDEX_BITS-1:0] fetch_idx;
  logic [BTB_TAG_BITS-1:0]   fetch_tag;
  logic [BTB_INDEX_BITS-1:0] upd_idx;
  logic [BTB_TAG_BITS-1:0]   upd_tag;
  logic                      fetch_match;
  logic                      upd_match;
  logic                      predict_taken;
  btb_entry_t                fetch_entry;
  btb_entry_t                upd_entry;

  assign fetch_idx = fetch_pc.word[ALIGN_BITS +: BTB_INDEX_BITS];
  assign fetch_tag = fetch_pc.word[PC_SIZE-1 -: BTB_TAG_BITS];
  assign upd_idx   = bp_update.pc[ALIGN_BITS +: BTB_INDEX_BITS];
  assign upd_tag   = bp_update.pc[PC_SIZE-1 -: BTB_TAG_BITS];

  assign fetch_entry = btb[fetch_idx];
  assign upd_entry   = btb[upd_idx];

  assign fetch_match   = btb_valid[fetch_idx] && (fetch_entry.tag == fetch_tag);
  assign upd_match     = btb_valid[upd_idx] && (upd_entry.tag == upd_tag);
  assign predict_taken = fetch_match && (fetch_entry.ctr >= 2'd2);

  // fall through is the next sequential instruction
  assign pred_pc.word = predict_taken ? fetch_entry.target
                                      : fetch_pc.word + PC_SIZE'(INSTR_BITS / 8);

  always_ff @(posedge clk) begin
    if (reset) begin
      btb_valid <= '0;
    end else if (bp_update.valid && bp_update.taken) begin
      btb_valid[upd_idx] <= 1'b1;
    end
  end

  // tag, target and counter of an entry
  always_ff @(posedge clk) begin
    if (bp_update.valid) begin
      if (bp_update.taken) begin
        btb[upd_idx].tag    <= upd_tag;
        btb[upd_idx].target <= bp_update.target;
        if (!upd_match) begin
          btb[upd_idx].ctr <= 2'd2;  // new entry starts weakly taken
        end else if (upd_entry.ctr != 2'd3) begin
          btb[upd_idx].ctr <= upd_entry.ctr + 2'd1;
        end
      end else if (upd_match && (upd_entry.ctr != 2'd0)) begin
        btb[upd_idx].ctr <= upd_entry.ctr - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  fetch_pkg::redirect_t   redirect,
  input  fetch_pkg::pc_u         pred_pc,
  input  logic                   cache_hit,
  input  fetch_pkg::cache_line_t cache_line,
  input  fetch_pkg::l1_fill_t    l1_fill,
  output fetch_pkg::pc_u         fetch_pc,
  output fetch_pkg::l1_req_t     l1_req,
  output fetch_pkg::fetch_out_t  fetch_out
);

  import fetch_pkg::*;

  logic                     waiting;   // miss sent and no fill yet
  logic                     hit_go;
  logic                     miss_go;
  logic [WORD_SEL_BITS-1:0] word_sel;
  logic [INSTR_BITS-1:0]    instr;

  assign hit_go  = !waiting && cache_hit && !redirect.valid;
  assign miss_go = !waiting && !cache_hit && !redirect.valid;  // a redirect drops the miss

  assign word_sel = fetch_pc.l0.offset[OFFSET_BITS-1 -: WORD_SEL_BITS];
  assign instr    = cache_line[word_sel * INSTR_BITS +: INSTR_BITS];

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_pc.word   <= RESET_PC;
      waiting         <= 1'b0;
      l1_req.valid    <= 1'b0;
      fetch_out.valid <= 1'b0;
    end else begin
      l1_req.valid    <= miss_go;  // single cycle pulse
      fetch_out.valid <= hit_go;

      if (redirect.valid) begin
        fetch_pc.word <= redirect.pc;  // taken even while waiting
      end else if (hit_go) begin
        fetch_pc <= pred_pc;
      end

      if (waiting && l1_fill.valid) begin
        waiting <= 1'b0;  // retry the lookup next cycle
      end else if (miss_go) begin
        waiting <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (miss_go) begin
      l1_req.pc <= fetch_pc;
    end
    if (hit_go) begin
      fetch_out.pc    <= fetch_pc.word;
      fetch_out.instr <= instr;
    end
  end

  // the L1 only sends a fill for a miss that was asked for
  a_fill_only_when_waiting : assert property (
    @(posedge clk) disable iff (reset)
    l1_fill.valid |-> waiting
  ) else $error("fetch: fill arrived with no miss outstanding");

endmodule

`default_nettype wire

// ==== rtl/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
  input  logic                  clk,
  input  logic                  reset,
  input  fetch_pkg::redirect_t  redirect,
  input  fetch_pkg::bp_update_t bp_update,
  input  fetch_pkg::mem_rsp_t   mem_rsp,
  output fetch_pkg::mem_req_t   mem_req,
  output fetch_pkg::fetch_out_t fetch_out
);

  import fetch_pkg::*;

  pc_u         fetch_pc;
  pc_u         pred_pc;
  logic        cache_hit;
  cache_line_t cache_line;
  l1_req_t     l1_req;
  l1_fill_t    l1_fill;  // goes to both the L0 and the fetch unit

  fetch_unit u_fetch (
    .clk        (clk),
    .reset      (reset),
    .redirect   (redirect),
    .pred_pc    (pred_pc),
    .cache_hit  (cache_hit),
    .cache_line (cache_line),
    .l1_fill    (l1_fill),
    .fetch_pc   (fetch_pc),
    .l1_req     (l1_req),
    .fetch_out  (fetch_out)
  );

  branch_predictor u_bp (
    .clk       (clk),
    .reset     (reset),
    .fetch_pc  (fetch_pc),
    .bp_update (bp_update),
    .pred_pc   (pred_pc)
  );

  l0_instruction_cache u_l0 (
    .clk        (clk),
    .reset      (reset),
    .bp_pred_pc (fetch_pc),  // looked up at the current fetch pc
    .l1_fill    (l1_fill),
    .cache_line (cache_line),
    .cache_hit  (cache_hit)
  );

  l1_instruction_cache u_l1 (
    .clk     (clk),
    .reset   (reset),
    .l1_req  (l1_req),
    .mem_rsp (mem_rsp),
    .mem_req (mem_req),
    .l1_fill (l1_fill)
  );

endmodule

`default_nettype wire

// ==== sim/fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

  import fetch_pkg::*;

  logic       clk = 1'b0;
  logic       reset;
  redirect_t  redirect;
  bp_update_t bp_update;
  mem_rsp_t   mem_rsp;
  mem_req_t   mem_req;
  fetch_out_t fetch_out;

  int          error_count = 0;
  int          timeout_count = 0;
  int          mem_req_count = 0;
  logic [31:0] exp_pcs[$];  // pcs still expected on fetch_out, in order

  fetch_top u_dut (
    .clk       (clk),
    .reset     (reset),
    .redirect  (redirect),
    .bp_update (bp_update),
    .mem_rsp   (mem_rsp),
    .mem_req   (mem_req),
    .fetch_out (fetch_out)
  );

  always #20 clk = ~clk;

  // every word of memory holds its own byte address with a fixed pattern
  function automatic logic [31:0] memory_word(input logic [31:0] byte_addr);
    return byte_addr ^ 32'hA5A5_0000;
  endfunction

  function automatic cache_line_t build_line(input logic [31:0] line_addr);
    cache_line_t line;
    for (int i = 0; i < 4; i++) begin
      line[32*i +: 32] = memory_word(line_addr + 32'(4 * i));  // lowest word at bit 0
    end
    return line;
  endfunction

  // line memory, one request at a time, 1 to 8 cycles of latency
  initial begin
    int unsigned delay;
    logic [31:0] line_addr;
    void'($urandom(37));
    mem_rsp = '0;
    forever begin
      @(negedge clk);
      if (!reset && mem_req.valid) begin
        mem_req_count++;
        line_addr = mem_req.addr;
        delay = 1 + ($urandom % 8);
        repeat (delay) @(negedge clk);
        mem_rsp.valid = 1'b1;
        mem_rsp.data  = build_line(line_addr);
        @(negedge clk);
        mem_rsp.valid = 1'b0;  // single cycle strobe
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      error_count++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    timeout_count++;
    $display("%s: timed out, %s", name, what);
  endtask

  // holding a redirect keeps the fetch pc still, no lookups and no misses
  task automatic park_fetch();
    redirect.valid = 1'b1;
    redirect.pc    = RESET_PC;
  endtask

  task automatic start_fetch(input logic [31:0] pc);
    @(negedge clk);
    redirect.valid = 1'b1;
    redirect.pc    = pc;
    @(negedge clk);
    redirect.valid = 1'b0;
  endtask

  task automatic push_sequence(input logic [31:0] first_pc, input int count);
    for (int i = 0; i < count; i++) begin
      exp_pcs.push_back(first_pc + 32'(4 * i));
    end
  endtask

  // check every valid fetch_out against the expected pcs, then park
  task automatic follow_path(input string name);
    logic [31:0] exp_pc;
    int          wait_cycles;
    while (exp_pcs.size() > 0) begin
      exp_pc = exp_pcs.pop_front();
      wait_cycles = 0;
      do begin
        @(negedge clk);
        wait_cycles++;
      end while (!fetch_out.valid && wait_cycles < 200);
      if (!fetch_out.valid) begin
        report_timeout(name, $sformatf("no instruction for pc %h", exp_pc));
        exp_pcs.delete();
      end else begin
        check_value({name, " pc"}, exp_pc, fetch_out.pc);
        check_value({name, " instr"}, memory_word(exp_pc), fetch_out.instr);
      end
    end
    park_fetch();  // same falling edge, so the next pc never misses
  endtask

  task automatic wait_mem_request(input string name);
    int wait_cycles;
    wait_cycles = 0;
    do begin
      @(negedge clk);
      wait_cycles++;
    end while (!mem_req.valid && wait_cycles < 200);
    if (!mem_req.valid) begin
      report_timeout(name, "no memory request was made");
    end
  endtask

  task automatic apply_update(input logic [31:0] pc, input logic [31:0] target,
                              input logic taken);
    @(negedge clk);
    bp_update.valid  = 1'b1;
    bp_update.taken  = taken;
    bp_update.pc     = pc;
    bp_update.target = target;
    @(negedge clk);
    bp_update.valid = 1'b0;
  endtask

  task automatic reset_test();
    reset = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_value("reset_test fetch valid", 32'd0, 32'(fetch_out.valid));
      check_value("reset_test mem_req valid", 32'd0, 32'(mem_req.valid));
    end
    reset = 1'b0;
    @(negedge clk);  // first cycle out of reset
    check_value("reset_test fetch valid", 32'd0, 32'(fetch_out.valid));
    check_value("reset_test mem_req valid", 32'd0, 32'(mem_req.valid));
  endtask

  // fetch starts on its own at the reset pc
  task automatic cold_fetch();
    int base;
    base = mem_req_count;
    push_sequence(RESET_PC, 12);
    follow_path("cold_fetch");
    check_value("cold_fetch mem requests", 32'd3, 32'(mem_req_count - base));
  endtask

  task automatic warm_refetch();
    int base;
    base = mem_req_count;
    start_fetch(32'h1000);
    push_sequence(32'h1000, 12);
    follow_path("warm_refetch");
    check_value("warm_refetch mem requests", 32'd0, 32'(mem_req_count - base));
  endtask

  // 0x1080 shares L0 sets with 0x1000 but not L1 sets
  task automatic conflict_refill();
    int base;
    base = mem_req_count;
    start_fetch(32'h1000);
    push_sequence(32'h1000, 8);
    follow_path("conflict_refill first");
    check_value("conflict_refill first mem requests", 32'd0, 32'(mem_req_count - base));
    base = mem_req_count;
    start_fetch(32'h1080);
    push_sequence(32'h1080, 8);
    follow_path("conflict_refill other");
    check_value("conflict_refill other mem requests", 32'd2, 32'(mem_req_count - base));
    base = mem_req_count;
    start_fetch(32'h1000);
    push_sequence(32'h1000, 8);
    follow_path("conflict_refill back");
    check_value("conflict_refill back mem requests", 32'd0, 32'(mem_req_count - base));
  endtask

  task automatic predicted_branch();
    int base;
    apply_update(32'h1008, 32'h1200, 1'b1);
    base = mem_req_count;
    start_fetch(32'h1000);
    push_sequence(32'h1000, 3);
    exp_pcs.push_back(32'h1200);  // taken branch at 0x1008
    follow_path("predicted_branch taken");
    check_value("predicted_branch taken mem requests", 32'd1, 32'(mem_req_count - base));
    apply_update(32'h1008, 32'h1200, 1'b0);
    apply_update(32'h1008, 32'h1200, 1'b0);  // counter down to 0
    base = mem_req_count;
    start_fetch(32'h1000);
    push_sequence(32'h1000, 5);
    follow_path("predicted_branch not taken");
    check_value("predicted_branch not taken mem requests", 32'd0,
                32'(mem_req_count - base));
  endtask

  task automatic redirect_midstream();
    int base;
    base = mem_req_count;
    start_fetch(32'h2000);
    wait_mem_request("redirect_midstream");
    redirect.valid = 1'b1;  // miss for 0x2000 still in flight
    redirect.pc    = 32'h3000;
    @(negedge clk);
    redirect.valid = 1'b0;
    push_sequence(32'h3000, 4);
    follow_path("redirect_midstream");
    check_value("redirect_midstream mem requests", 32'd2, 32'(mem_req_count - base));
  endtask

  initial begin
    reset     = 1'b1;
    redirect  = '0;
    bp_update = '0;
    reset_test();
    cold_fetch();
    warm_refetch();
    conflict_refill();
    predicted_branch();
    redirect_midstream();
    repeat (2) @(negedge clk);
    $display("errors %0d, timeouts %0d, memory requests %0d",
             error_count, timeout_count, mem_req_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/fetch_pkg.sv
rtl/l0_instruction_cache.sv
rtl/l1_instruction_cache.sv
rtl/branch_predictor.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module fetch_tb \
  -o fetch_sim

./obj_dir/fetch_sim > sim.log
cat sim.log

grep -q "Regression passed" sim.log
